// ==== common/extmem_pkg.sv ====
package extmem_pkg;

  // ------------------------------------------------------------
  // Widths and counts
  // ------------------------------------------------------------
  localparam int addr_w = 8;
  localparam int elem_w = 16;
  localparam int tag_w = 2;

  // Legal tags run from 0 up to count - 1
  localparam int ld_count = 3;
  localparam int st_count = 2;

  localparam int queue_depth = 4;
  localparam int pair_timeout = 16;
  localparam int mem_depth = 256;

  // ------------------------------------------------------------
  // Error codes
  // ------------------------------------------------------------
  localparam int err_w = 16;
  localparam logic [err_w-1:0] err_tag_oob = 16'h0021;
  localparam logic [err_w-1:0] err_pair_timeout = 16'h0022;

  // ------------------------------------------------------------
  // Channel payloads
  // ------------------------------------------------------------
  typedef struct packed {
    logic [tag_w-1:0]  tag;
    logic [addr_w-1:0] addr;
  } ld_req_t;

  typedef struct packed {
    logic [tag_w-1:0]  tag;
    logic [addr_w-1:0] addr;
  } st_addr_t;

  typedef struct packed {
    logic [tag_w-1:0]  tag;
    logic [elem_w-1:0] data;
  } st_data_t;

  typedef struct packed {
    logic [tag_w-1:0]  tag;
    logic [elem_w-1:0] data;
  } ld_rsp_t;

  // Write port from the store pairing logic into the memory
  typedef struct packed {
    logic              en;
    logic [addr_w-1:0] addr;
    logic [elem_w-1:0] data;
  } mem_wr_t;

endpackage

// ==== store/store_tag_queue.sv ====
`timescale 1ns/1ps

module store_tag_queue
  import extmem_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              addr_push,
  input  logic [addr_w-1:0] addr_in,
  input  logic              data_push,
  input  logic [elem_w-1:0] data_in,
  input  logic              pop,
  output logic              addr_full,
  output logic              data_full,
  output logic              pair_ready,
  output logic              half_waiting,
  output logic [addr_w-1:0] head_addr,
  output logic [elem_w-1:0] head_data
);

  typedef logic [$clog2(queue_depth)-1:0] ptr_t;
  typedef logic [$clog2(queue_depth):0] cnt_t;

  logic [addr_w-1:0] addr_mem [queue_depth];
  logic [elem_w-1:0] data_mem [queue_depth];
  ptr_t addr_wr_ptr;
  ptr_t addr_rd_ptr;
  ptr_t data_wr_ptr;
  ptr_t data_rd_ptr;
  cnt_t addr_cnt;
  cnt_t data_cnt;
  logic addr_empty;
  logic data_empty;

  function automatic ptr_t next_ptr(input ptr_t p);
    return (p == ptr_t'(queue_depth - 1)) ? '0 : p + ptr_t'(1);
  endfunction

  assign addr_full  = (addr_cnt == cnt_t'(queue_depth));
  assign data_full  = (data_cnt == cnt_t'(queue_depth));
  assign addr_empty = (addr_cnt == '0);
  assign data_empty = (data_cnt == '0);

  assign pair_ready   = !addr_empty && !data_empty;
  assign half_waiting = addr_empty != data_empty;

  assign head_addr = addr_mem[addr_rd_ptr];
  assign head_data = data_mem[data_rd_ptr];

  // ------------------------------------------------------------
  // Address FIFO
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_wr_ptr <= '0;
      addr_rd_ptr <= '0;
      addr_cnt    <= '0;
    end else begin
      if (addr_push) begin
        addr_wr_ptr <= next_ptr(addr_wr_ptr);
      end
      if (pop) begin
        addr_rd_ptr <= next_ptr(addr_rd_ptr);
      end
      // Push and pop together leave the count alone
      if (addr_push && !pop) begin
        addr_cnt <= addr_cnt + cnt_t'(1);
      end else if (pop && !addr_push) begin
        addr_cnt <= addr_cnt - cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (addr_push) begin
      addr_mem[addr_wr_ptr] <= addr_in;
    end
  end

  // ------------------------------------------------------------
  // Data FIFO
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_wr_ptr <= '0;
      data_rd_ptr <= '0;
      data_cnt    <= '0;
    end else begin
      if (data_push) begin
        data_wr_ptr <= next_ptr(data_wr_ptr);
      end
      if (pop) begin
        data_rd_ptr <= next_ptr(data_rd_ptr);
      end
      if (data_push && !pop) begin
        data_cnt <= data_cnt + cnt_t'(1);
      end else if (pop && !data_push) begin
        data_cnt <= data_cnt - cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (data_push) begin
      data_mem[data_wr_ptr] <= data_in;
    end
  end

endmodule

// ==== store/store_pair_unit.sv ====
`timescale 1ns/1ps

module store_pair_unit
  import extmem_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  st_addr_t            st_addr,
  input  logic                st_addr_valid,
  output logic                st_addr_ready,
  input  st_data_t            st_data,
  input  logic                st_data_valid,
  output logic                st_data_ready,
  input  logic                st_addr_tag_ok,
  input  logic                st_data_tag_ok,
  output logic [tag_w-1:0]    st_done_tag,
  output logic                st_done_valid,
  input  logic                st_done_ready,
  output mem_wr_t             mem_wr,
  output logic [st_count-1:0] half_waiting
);

  logic [st_count-1:0] addr_push;
  logic [st_count-1:0] data_push;
  logic [st_count-1:0] addr_full;
  logic [st_count-1:0] data_full;
  logic [st_count-1:0] pair_ready;
  logic [st_count-1:0] grant;
  logic [st_count-1:0] pop;
  logic [addr_w-1:0]   head_addr [st_count];
  logic [elem_w-1:0]   head_data [st_count];

  // ------------------------------------------------------------
  // One address/data queue pair per store tag
  // ------------------------------------------------------------
  for (genvar i = 0; i < st_count; i++) begin : g_queue
    store_tag_queue queue0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .addr_push    (addr_push[i]),
      .addr_in      (st_addr.addr),
      .data_push    (data_push[i]),
      .data_in      (st_data.data),
      .pop          (pop[i]),
      .addr_full    (addr_full[i]),
      .data_full    (data_full[i]),
      .pair_ready   (pair_ready[i]),
      .half_waiting (half_waiting[i]),
      .head_addr    (head_addr[i]),
      .head_data    (head_data[i])
    );
  end

  // Ready looks at the tag and the target queue only, never at valid
  always_comb begin : route
    addr_push     = '0;
    data_push     = '0;
    st_addr_ready = 1'b0;
    st_data_ready = 1'b0;
    for (int i = 0; i < st_count; i++) begin
      if (st_addr.tag == tag_w'(i)) begin
        st_addr_ready = st_addr_tag_ok && !addr_full[i];
        addr_push[i]  = st_addr_valid && st_addr_tag_ok && !addr_full[i];
      end
      if (st_data.tag == tag_w'(i)) begin
        st_data_ready = st_data_tag_ok && !data_full[i];
        data_push[i]  = st_data_valid && st_data_tag_ok && !data_full[i];
      end
    end
  end

  // ------------------------------------------------------------
  // Pair grant, lowest tag first
  // ------------------------------------------------------------
  always_comb begin : grant_select
    grant       = '0;
    st_done_tag = '0;
    // Walk downward so the lowest ready tag is the last one kept
    for (int i = st_count - 1; i >= 0; i--) begin
      if (pair_ready[i]) begin
        grant       = '0;
        grant[i]    = 1'b1;
        st_done_tag = tag_w'(i);
      end
    end
  end

  assign st_done_valid = |pair_ready;
  assign pop = grant & {st_count{st_done_ready}};

  // Memory write happens on the same edge as the st_done transfer
  always_comb begin : write_port
    mem_wr.en   = st_done_valid && st_done_ready;
    mem_wr.addr = '0;
    mem_wr.data = '0;
    for (int i = 0; i < st_count; i++) begin
      if (grant[i]) begin
        mem_wr.addr = head_addr[i];
        mem_wr.data = head_data[i];
      end
    end
  end

endmodule

// ==== verilog/pair_wait_timer.sv ====
`timescale 1ns/1ps

module pair_wait_timer
  import extmem_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic [st_count-1:0] half_waiting,
  output logic [st_count-1:0] timeout_hit
);

  typedef logic [$clog2(pair_timeout + 1)-1:0] wait_cnt_t;

  for (genvar i = 0; i < st_count; i++) begin : g_tag
    wait_cnt_t wait_cnt;

    // Saturating count of cycles spent with only one half queued
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        wait_cnt <= '0;
      end else if (!half_waiting[i]) begin
        wait_cnt <= '0;
      end else if (wait_cnt != wait_cnt_t'(pair_timeout)) begin
        wait_cnt <= wait_cnt + wait_cnt_t'(1);
      end
    end

    assign timeout_hit[i] = (wait_cnt == wait_cnt_t'(pair_timeout));
  end

endmodule

// ==== verilog/fault_monitor.sv ====
`timescale 1ns/1ps

module fault_monitor
  import extmem_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  ld_req_t             ld_req,
  input  st_addr_t            st_addr,
  input  st_data_t            st_data,
  input  logic                ld_req_valid,
  input  logic                st_addr_valid,
  input  logic                st_data_valid,
  input  logic [st_count-1:0] timeout_hit,
  output logic                ld_tag_ok,
  output logic                st_addr_tag_ok,
  output logic                st_data_tag_ok,
  output logic                error_valid,
  output logic [err_w-1:0]    error_code
);

  typedef enum logic {
    fm_clear,
    fm_latched
  } fm_state_t;

  fm_state_t state;
  logic tag_fault;
  logic timeout_fault;

  // Tag range checks
  assign ld_tag_ok      = ld_req.tag < tag_w'(ld_count);
  assign st_addr_tag_ok = st_addr.tag < tag_w'(st_count);
  assign st_data_tag_ok = st_data.tag < tag_w'(st_count);

  assign tag_fault = (ld_req_valid && !ld_tag_ok) ||
                     (st_addr_valid && !st_addr_tag_ok) ||
                     (st_data_valid && !st_data_tag_ok);
  assign timeout_fault = |timeout_hit;

  // ------------------------------------------------------------
  // First fault wins, held until reset
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= fm_clear;
      error_code <= '0;
    end else if (state == fm_clear) begin
      if (tag_fault) begin
        state      <= fm_latched;
        error_code <= err_tag_oob;
      end else if (timeout_fault) begin
        state      <= fm_latched;
        error_code <= err_pair_timeout;
      end
    end
  end

  assign error_valid = (state == fm_latched);

endmodule

// ==== verilog/mem_array.sv ====
`timescale 1ns/1ps

module mem_array
  import extmem_pkg::*;
(
  input  logic             clk,
  input  ld_req_t          ld_req,
  input  logic             ld_req_valid,
  output logic             ld_req_ready,
  input  logic             ld_tag_ok,
  output ld_rsp_t          ld_data,
  output logic             ld_data_valid,
  input  logic             ld_data_ready,
  output logic [tag_w-1:0] ld_done_tag,
  output logic             ld_done_valid,
  input  logic             ld_done_ready,
  input  mem_wr_t          mem_wr
);

  logic [elem_w-1:0] mem [mem_depth];

  // ------------------------------------------------------------
  // Write port from the store path
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (mem_wr.en) begin
      mem[mem_wr.addr] <= mem_wr.data;
    end
  end

  // ------------------------------------------------------------
  // Load path, answered in the same cycle
  // ------------------------------------------------------------
  // Data and done form one completion, each output waits on its partner
  assign ld_req_ready  = ld_tag_ok && ld_data_ready && ld_done_ready;
  assign ld_data_valid = ld_req_valid && ld_tag_ok && ld_done_ready;
  assign ld_done_valid = ld_req_valid && ld_tag_ok && ld_data_ready;

  assign ld_data.tag  = ld_req.tag;
  assign ld_data.data = mem[ld_req.addr];
  assign ld_done_tag  = ld_req.tag;

endmodule

// ==== verilog/extmem_top.sv ====
`timescale 1ns/1ps

module extmem_top
  import extmem_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  ld_req_t          ld_req,
  input  logic             ld_req_valid,
  output logic             ld_req_ready,
  output ld_rsp_t          ld_data,
  output logic             ld_data_valid,
  input  logic             ld_data_ready,
  output logic [tag_w-1:0] ld_done_tag,
  output logic             ld_done_valid,
  input  logic             ld_done_ready,
  input  st_addr_t         st_addr,
  input  logic             st_addr_valid,
  output logic             st_addr_ready,
  input  st_data_t         st_data,
  input  logic             st_data_valid,
  output logic             st_data_ready,
  output logic [tag_w-1:0] st_done_tag,
  output logic             st_done_valid,
  input  logic             st_done_ready,
  output logic             error_valid,
  output logic [err_w-1:0] error_code
);

  logic                ld_tag_ok;
  logic                st_addr_tag_ok;
  logic                st_data_tag_ok;
  logic [st_count-1:0] half_waiting;
  logic [st_count-1:0] timeout_hit;
  mem_wr_t             mem_wr;

  // ------------------------------------------------------------
  // Store pairing
  // ------------------------------------------------------------
  store_pair_unit store0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .st_addr        (st_addr),
    .st_addr_valid  (st_addr_valid),
    .st_addr_ready  (st_addr_ready),
    .st_data        (st_data),
    .st_data_valid  (st_data_valid),
    .st_data_ready  (st_data_ready),
    .st_addr_tag_ok (st_addr_tag_ok),
    .st_data_tag_ok (st_data_tag_ok),
    .st_done_tag    (st_done_tag),
    .st_done_valid  (st_done_valid),
    .st_done_ready  (st_done_ready),
    .mem_wr         (mem_wr),
    .half_waiting   (half_waiting)
  );

  pair_wait_timer timer0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .half_waiting (half_waiting),
    .timeout_hit  (timeout_hit)
  );

  // ------------------------------------------------------------
  // Tag checks and error latch
  // ------------------------------------------------------------
  fault_monitor monitor0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .ld_req         (ld_req),
    .st_addr        (st_addr),
    .st_data        (st_data),
    .ld_req_valid   (ld_req_valid),
    .st_addr_valid  (st_addr_valid),
    .st_data_valid  (st_data_valid),
    .timeout_hit    (timeout_hit),
    .ld_tag_ok      (ld_tag_ok),
    .st_addr_tag_ok (st_addr_tag_ok),
    .st_data_tag_ok (st_data_tag_ok),
    .error_valid    (error_valid),
    .error_code     (error_code)
  );

  // ------------------------------------------------------------
  // Memory and load path
  // ------------------------------------------------------------
  mem_array mem0 (
    .clk           (clk),
    .ld_req        (ld_req),
    .ld_req_valid  (ld_req_valid),
    .ld_req_ready  (ld_req_ready),
    .ld_tag_ok     (ld_tag_ok),
    .ld_data       (ld_data),
    .ld_data_valid (ld_data_valid),
    .ld_data_ready (ld_data_ready),
    .ld_done_tag   (ld_done_tag),
    .ld_done_valid (ld_done_valid),
    .ld_done_ready (ld_done_ready),
    .mem_wr        (mem_wr)
  );

endmodule

// ==== dv/extmem_chk.sv ====
`timescale 1ns/1ps

module extmem_chk
  import extmem_pkg::*;
(
  input logic             clk,
  input logic             rst_n,
  input ld_rsp_t          ld_data,
  input logic             ld_data_valid,
  input logic             ld_data_ready,
  input logic             ld_done_valid,
  input logic             ld_done_ready,
  input st_addr_t         st_addr,
  input logic             st_addr_valid,
  input logic             st_addr_ready,
  input logic             error_valid,
  input logic [err_w-1:0] error_code
);

  // Load data and load done transfer as one joined completion
  ld_joined: assert property (@(posedge clk) disable iff (!rst_n)
    (ld_data_valid && ld_data_ready) == (ld_done_valid && ld_done_ready))
    else $error("load data and load done transferred apart");

  // ------------------------------------------------------------
  // Payloads held while stalled
  // ------------------------------------------------------------
  ld_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ld_data_valid && !ld_data_ready |=> ld_data_valid && $stable(ld_data))
    else $error("load payload changed under stall");

  st_addr_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
    st_addr_valid && !st_addr_ready |=> st_addr_valid && $stable(st_addr))
    else $error("store address changed under stall");

  // Latched error code never moves
  err_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    error_valid |=> error_valid && $stable(error_code))
    else $error("error code changed while latched");

endmodule

// ==== dv/extmem_tb.sv ====
`timescale 1ns/1ps

module extmem_tb
  import extmem_pkg::*;
;

  logic             clk;
  logic             rst_n;
  ld_req_t          ld_req;
  logic             ld_req_valid;
  logic             ld_req_ready;
  ld_rsp_t          ld_data;
  logic             ld_data_valid;
  logic             ld_data_ready;
  logic [tag_w-1:0] ld_done_tag;
  logic             ld_done_valid;
  logic             ld_done_ready;
  st_addr_t         st_addr;
  logic             st_addr_valid;
  logic             st_addr_ready;
  st_data_t         st_data;
  logic             st_data_valid;
  logic             st_data_ready;
  logic [tag_w-1:0] st_done_tag;
  logic             st_done_valid;
  logic             st_done_ready;
  logic             error_valid;
  logic [err_w-1:0] error_code;

  int seed = 32'h1a14_a58e;
  int errors = 0;
  int checks = 0;
  int n_ops = 0;

  // Reference memory and the store halves still waiting for a partner
  logic [elem_w-1:0] model [mem_depth];
  logic [addr_w-1:0] pend_addr0 [$];
  logic [addr_w-1:0] pend_addr1 [$];
  logic [elem_w-1:0] pend_data0 [$];
  logic [elem_w-1:0] pend_data1 [$];
  logic [addr_w-1:0] done_addr;
  logic [elem_w-1:0] done_data;
  logic [tag_w-1:0]  exp_tag;
  bit                pair_found;

  // Parsed stimulus records
  string       op_q [$];
  logic [31:0] tag_q [$];
  logic [31:0] addr_q [$];
  logic [31:0] data_q [$];
  logic [31:0] exp_q [$];

  extmem_top dut0 (.*);

  bind extmem_top extmem_chk chk0 (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic report_value(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
    errors++;
    $display("[FAIL] %s expected 0x%0h got 0x%0h", name, exp, got);
  endtask

  task automatic report_event(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  function automatic bit pairs_pending();
    return (pend_addr0.size() > 0 && pend_data0.size() > 0) ||
           (pend_addr1.size() > 0 && pend_data1.size() > 0);
  endfunction

  // ------------------------------------------------------------
  // Store completions update the reference memory
  // ------------------------------------------------------------
  always @(negedge clk) begin
    if (rst_n && st_done_valid && st_done_ready) begin
      checks++;
      pair_found = 1'b1;
      // Lowest tag holding a matched pair completes first
      if (pend_addr0.size() > 0 && pend_data0.size() > 0) begin
        exp_tag   = 2'd0;
        done_addr = pend_addr0.pop_front();
        done_data = pend_data0.pop_front();
      end else if (pend_addr1.size() > 0 && pend_data1.size() > 0) begin
        exp_tag   = 2'd1;
        done_addr = pend_addr1.pop_front();
        done_data = pend_data1.pop_front();
      end else begin
        pair_found = 1'b0;
        report_event("store completed with no matched pair pending");
      end
      if (pair_found) begin
        if (st_done_tag !== exp_tag) begin
          report_value("st_done_tag", 32'(exp_tag), 32'(st_done_tag));
        end
        model[done_addr] = done_data;
      end
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    pend_addr0.delete();
    pend_addr1.delete();
    pend_data0.delete();
    pend_data1.delete();
    @(negedge clk);
    checks++;
    if (error_valid !== 1'b0) report_value("error_valid", 0, 32'(error_valid));
    if (error_code !== '0) report_value("error_code", 0, 32'(error_code));
    if (ld_data_valid !== 1'b0) report_value("ld_data_valid", 0, 32'(ld_data_valid));
    if (st_done_valid !== 1'b0) report_value("st_done_valid", 0, 32'(st_done_valid));
  endtask

  task automatic send_addr(input logic [tag_w-1:0] tag, input logic [addr_w-1:0] addr);
    int  cyc;
    bit  acc;
    cyc = 0;
    acc = 0;
    @(posedge clk);
    st_addr.tag   <= tag;
    st_addr.addr  <= addr;
    st_addr_valid <= 1'b1;
    while (!acc && cyc < 32) begin
      @(negedge clk);
      if (st_addr_ready) acc = 1;
      else cyc++;
      @(posedge clk);
    end
    st_addr_valid <= 1'b0;
    if (!acc) report_event("store address was never accepted");
    else if (tag == 2'd0) pend_addr0.push_back(addr);
    else pend_addr1.push_back(addr);
  endtask

  task automatic send_data(input logic [tag_w-1:0] tag, input logic [elem_w-1:0] data);
    int  cyc;
    bit  acc;
    cyc = 0;
    acc = 0;
    @(posedge clk);
    st_data.tag   <= tag;
    st_data.data  <= data;
    st_data_valid <= 1'b1;
    while (!acc && cyc < 32) begin
      @(negedge clk);
      if (st_data_ready) acc = 1;
      else cyc++;
      @(posedge clk);
    end
    st_data_valid <= 1'b0;
    if (!acc) report_event("store data was never accepted");
    else if (tag == 2'd0) pend_data0.push_back(data);
    else pend_data1.push_back(data);
  endtask

  // Wait until every matched pair has completed
  task automatic drain_stores();
    int cyc;
    cyc = 0;
    while (pairs_pending() && cyc < 64) begin
      @(negedge clk);
      cyc++;
    end
    if (pairs_pending()) report_event("matched store pairs never completed");
    @(posedge clk);
  endtask

  task automatic run_load(input logic [tag_w-1:0] tag, input logic [addr_w-1:0] addr,
                          input logic [elem_w-1:0] exp, input bit stall);
    int cyc;
    int rnd;
    bit done;
    cyc = 0;
    done = 0;
    checks++;
    if (exp !== model[addr]) report_event("stimulus value disagrees with reference memory");
    @(posedge clk);
    ld_req.tag    <= tag;
    ld_req.addr   <= addr;
    ld_req_valid  <= 1'b1;
    ld_data_ready <= !stall;
    while (!done && cyc < 64) begin
      @(negedge clk);
      checks++;
      if (ld_data_valid !== 1'b1) report_value("ld_data_valid", 1, 32'(ld_data_valid));
      if (ld_data.data !== model[addr]) begin
        report_value("ld_data.data", 32'(model[addr]), 32'(ld_data.data));
      end
      if (ld_data_ready) begin
        if (ld_req_ready !== 1'b1) report_value("ld_req_ready", 1, 32'(ld_req_ready));
        if (ld_done_valid !== 1'b1) report_value("ld_done_valid", 1, 32'(ld_done_valid));
        if (ld_data.tag !== tag) report_value("ld_data.tag", 32'(tag), 32'(ld_data.tag));
        if (ld_done_tag !== tag) report_value("ld_done_tag", 32'(tag), 32'(ld_done_tag));
        done = 1;
      end else begin
        // Stalled, nothing may complete
        if (ld_req_ready !== 1'b0) report_value("ld_req_ready", 0, 32'(ld_req_ready));
        if (ld_done_valid !== 1'b0) report_value("ld_done_valid", 0, 32'(ld_done_valid));
        cyc++;
      end
      @(posedge clk);
      if (!done) begin
        rnd = $random(seed);
        ld_data_ready <= rnd[0];
      end
    end
    if (!done) report_event("load never completed under stalls");
    ld_req_valid  <= 1'b0;
    ld_data_ready <= 1'b1;
  endtask

  task automatic check_timeout(input logic [tag_w-1:0] tag, input logic [addr_w-1:0] addr,
                               input logic [err_w-1:0] exp);
    int cyc;
    cyc = 0;
    send_addr(tag, addr);
    while (!error_valid && cyc < pair_timeout + 4) begin
      @(negedge clk);
      cyc++;
    end
    checks++;
    if (!error_valid) report_event("error_valid not raised within the pair timeout window");
    else if (error_code !== exp) report_value("error_code", 32'(exp), 32'(error_code));
  endtask

  task automatic check_bad_load(input logic [tag_w-1:0] tag, input logic [addr_w-1:0] addr,
                                input logic [err_w-1:0] exp);
    @(posedge clk);
    ld_req.tag   <= tag;
    ld_req.addr  <= addr;
    ld_req_valid <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      checks++;
      if (ld_req_ready !== 1'b0) report_value("ld_req_ready", 0, 32'(ld_req_ready));
      if (ld_data_valid !== 1'b0) report_value("ld_data_valid", 0, 32'(ld_data_valid));
    end
    checks++;
    if (error_valid !== 1'b1) report_value("error_valid", 1, 32'(error_valid));
    if (error_code !== exp) report_value("error_code", 32'(exp), 32'(error_code));
    @(posedge clk);
    ld_req_valid <= 1'b0;
  endtask

  // ------------------------------------------------------------
  // Stimulus file and main sequence
  // ------------------------------------------------------------
  initial begin
    int          fd;
    int          r;
    string       line;
    string       op;
    logic [31:0] f_tag;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_exp;
    rst_n = 1'b0;
    ld_req = '0;
    ld_req_valid = 1'b0;
    ld_data_ready = 1'b1;
    ld_done_ready = 1'b1;
    st_addr = '0;
    st_addr_valid = 1'b0;
    st_data = '0;
    st_data_valid = 1'b0;
    st_done_ready = 1'b1;
    for (int i = 0; i < mem_depth; i++) model[i] = '0;
    fd = $fopen("dv/extmem_stim.txt", "r");
    if (fd == 0) begin
      report_event("could not open the stimulus file");
    end else begin
      while (!$feof(fd)) begin
        r = $fgets(line, fd);
        if (r == 0 || line.len() < 2 || line.getc(0) == "#") continue;
        r = $sscanf(line, "%s %h %h %h %h", op, f_tag, f_addr, f_data, f_exp);
        if (r != 5) continue;
        op_q.push_back(op);
        tag_q.push_back(f_tag);
        addr_q.push_back(f_addr);
        data_q.push_back(f_data);
        exp_q.push_back(f_exp);
      end
      $fclose(fd);
    end
    n_ops = op_q.size();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < n_ops; i++) begin
      if (op_q[i] == "reset") begin
        apply_reset();
      end else if (op_q[i] == "st") begin
        send_addr(tag_q[i][1:0], addr_q[i][7:0]);
        send_data(tag_q[i][1:0], data_q[i][15:0]);
        drain_stores();
      end else if (op_q[i] == "sa") begin
        send_addr(tag_q[i][1:0], addr_q[i][7:0]);
      end else if (op_q[i] == "sd") begin
        send_data(tag_q[i][1:0], data_q[i][15:0]);
      end else if (op_q[i] == "drain") begin
        drain_stores();
      end else if (op_q[i] == "ld") begin
        run_load(tag_q[i][1:0], addr_q[i][7:0], exp_q[i][15:0], 1'b0);
      end else if (op_q[i] == "ldst") begin
        run_load(tag_q[i][1:0], addr_q[i][7:0], exp_q[i][15:0], 1'b1);
      end else if (op_q[i] == "to") begin
        check_timeout(tag_q[i][1:0], addr_q[i][7:0], exp_q[i][15:0]);
      end else if (op_q[i] == "oob") begin
        check_bad_load(tag_q[i][1:0], addr_q[i][7:0], exp_q[i][15:0]);
      end else begin
        report_event("unknown operation in the stimulus file");
      end
    end
    repeat (2) @(posedge clk);
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog, 200 cycles per stimulus record
  initial begin
    wait (n_ops > 0);
    repeat (n_ops * 200) @(posedge clk);
    $display("Watchdog expired before the stimulus finished");
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== dv/extmem_stim.txt ====
# Columns, all hex: op tag addr data expected
# Ops: reset st sa sd drain ld ldst (stalled load) to (pair timeout) oob (bad load tag)
reset 0 00 0000 0000
st 0 10 beef 0000
ld 0 10 0000 beef
ld 2 10 0000 beef
sa 0 20 0000 0000
sa 1 21 0000 0000
sa 0 22 0000 0000
sd 1 00 1111 0000
sd 0 00 2222 0000
sd 0 00 3333 0000
drain 0 00 0000 0000
ld 0 20 0000 2222
ld 1 21 0000 1111
ld 2 22 0000 3333
ldst 1 10 0000 beef
ldst 0 21 0000 1111
ldst 2 20 0000 2222
reset 0 00 0000 0000
to 1 30 0000 0022
reset 0 00 0000 0000
oob 3 10 0000 0021
reset 0 00 0000 0000
ld 0 10 0000 beef

// ==== build.f ====
common/extmem_pkg.sv
store/store_tag_queue.sv
store/store_pair_unit.sv
verilog/pair_wait_timer.sv
verilog/fault_monitor.sv
verilog/mem_array.sv
verilog/extmem_top.sv
dv/extmem_chk.sv
dv/extmem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= extmem_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell cat build.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): build.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f build.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
